/* flist.f */
verilog/saturn_bus_pkg.sv
verilog/saturn_map_pkg.sv
verilog/saturn_nibble_bus_if.sv
verilog/saturn_bus_controller.sv
verilog/saturn_rom.sv
verilog/saturn_ram.sv
verilog/saturn_bus_combiner.sv
verilog/saturn_bus.sv
verification/saturn_bus_chk.sv
verification/saturn_bus_monitor.sv
verification/tb_saturn_bus.sv

/* Makefile */
# Verilator build and run of the Saturn bus testbench

.PHONY: run lint clean

run:
	verilator --binary --timing --assert --top-module tb_saturn_bus -f flist.f -o sim_tb
	-./obj_dir/sim_tb > sim.log 2>&1
	cat sim.log
	grep -q "Simulation PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module tb_saturn_bus -f flist.f

clean:
	rm -rf obj_dir sim.log

/* verification/tb_saturn_bus.sv */
// Saturn bus testbench driving random ROM, RAM, unmapped and dropped requests
`timescale 1ns/1ps
`default_nettype none

module tb_saturn_bus;

    localparam logic [3:0] ROM_BANK      = 4'd0;
    localparam logic [3:0] RAM_BANK      = 4'd1;
    localparam int         RAM_ADDR_BITS = 6;
    localparam int         TIMEOUT       = 24;

    logic                              i_clk = 1'b0;
    logic                              i_reset;
    logic                              i_req;
    logic                              i_req_write;
    logic [saturn_map_pkg::ADDR_W-1:0] i_req_addr;
    logic [3:0]                        i_req_wdata;
    logic                              o_busy;
    logic                              o_resp_valid;
    logic                              o_resp_hit;
    logic [3:0]                        o_resp_data;
    logic [1:0]                        o_phase;
    logic [31:0]                       o_cycle_ctr;

    // Expected answer handed to the monitor at acceptance
    logic       exp_push;
    logic       exp_hit;
    logic [3:0] exp_data;
    int         mon_errors;
    int         mon_responses;
    int         mon_pending;

    // Shadow of the nibble RAM and the indices written so far
    logic [3:0]               shadow_ram [0:(1 << RAM_ADDR_BITS)-1];
    logic [RAM_ADDR_BITS-1:0] written [$];

    int tb_errors     = 0;
    int errors_before = 0;
    int tests_run     = 0;
    int accepted      = 0;

    always #50 i_clk = ~i_clk;

    saturn_bus #(
        .ROM_BANK      (ROM_BANK),
        .RAM_BANK      (RAM_BANK),
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) DUT (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req        (i_req),
        .i_req_write  (i_req_write),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .o_busy       (o_busy),
        .o_resp_valid (o_resp_valid),
        .o_resp_hit   (o_resp_hit),
        .o_resp_data  (o_resp_data),
        .o_phase      (o_phase),
        .o_cycle_ctr  (o_cycle_ctr)
    );

    saturn_bus_monitor monitor (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_resp_valid  (o_resp_valid),
        .i_resp_hit    (o_resp_hit),
        .i_resp_data   (o_resp_data),
        .i_exp_push    (exp_push),
        .i_exp_hit     (exp_hit),
        .i_exp_data    (exp_data),
        .o_error_count (mon_errors),
        .o_resp_count  (mon_responses),
        .o_pending     (mon_pending)
    );

    // Expected {hit, data} from the bank map, ROM rule and shadow RAM
    function automatic logic [4:0] reference_response(input logic write, input logic [19:0] addr);
        logic [3:0]  bank;
        logic [15:0] offset;
        bank   = addr[19:16];
        offset = addr[15:0];
        // RAM answers last, so it wins a shared bank
        if (bank == RAM_BANK) begin
            return write ? 5'h10 : {1'b1, shadow_ram[offset[RAM_ADDR_BITS-1:0]]};
        end
        if (bank == ROM_BANK) begin
            return write ? 5'h10 : {1'b1, 4'(offset[3:0] + offset[11:8] + offset[15:12])};
        end
        return 5'h00;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout waiting for %s", what);
        tb_errors++;
    endtask

    // Returns on an edge where o_busy was low in the cycle before
    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge i_clk);
        while (o_busy && n < TIMEOUT) begin
            @(posedge i_clk);
            n++;
        end
        if (o_busy) report_timeout("o_busy to fall");
    endtask

    // One accepted request, optionally followed by a request that must be dropped
    task automatic run_transaction(input logic write, input logic [19:0] addr,
                                   input logic [3:0] wdata, input logic drop_extra);
        logic [4:0] expected;
        int         cycles;
        // Random gap moves the accepting phase around the ring
        repeat ($urandom_range(0, 3)) @(posedge i_clk);
        wait_idle();
        i_req       <= 1'b1;
        i_req_write <= write;
        i_req_addr  <= addr;
        i_req_wdata <= wdata;
        @(posedge i_clk);
        cycles   = 1;
        expected = reference_response(write, addr);
        exp_push <= 1'b1;
        exp_hit  <= expected[4];
        exp_data <= expected[3:0];
        if (write && addr[19:16] == RAM_BANK) begin
            shadow_ram[addr[RAM_ADDR_BITS-1:0]] = wdata;
        end
        accepted++;
        if (drop_extra) begin
            // Busy now, so this RAM write must vanish
            i_req_write <= 1'b1;
            i_req_addr  <= {RAM_BANK, 16'($urandom)};
            i_req_wdata <= 4'($urandom);
        end else begin
            i_req <= 1'b0;
        end
        @(posedge i_clk);
        cycles++;
        exp_push <= 1'b0;
        // Busy rises on the clock that accepts the request
        if (o_busy !== 1'b1) begin
            $display("mismatch o_busy: expected 0x1 got 0x%h", o_busy);
            tb_errors++;
        end
        @(posedge i_clk);
        cycles++;
        i_req <= 1'b0;
        while (!o_resp_valid && cycles < TIMEOUT) begin
            @(posedge i_clk);
            cycles++;
        end
        if (!o_resp_valid) begin
            report_timeout("o_resp_valid");
        end else if (cycles - 1 < 5 || cycles - 1 > 8) begin
            $display("response came %0d cycles after the request, outside 5 to 8", cycles - 1);
            tb_errors++;
        end
    endtask

    // Free running ring straight after reset
    task automatic check_ring();
        for (int n = 1; n <= 16; n++) begin
            @(posedge i_clk);
            if (o_phase !== 2'((n - 1) % 4)) begin
                $display("mismatch o_phase: expected 0x%h got 0x%h", 2'((n - 1) % 4), o_phase);
                tb_errors++;
            end
            if (o_cycle_ctr !== 32'((n - 1) / 4)) begin
                $display("mismatch o_cycle_ctr: expected 0x%h got 0x%h",
                         32'((n - 1) / 4), o_cycle_ctr);
                tb_errors++;
            end
            if (o_busy !== 1'b0 || o_resp_valid !== 1'b0) begin
                $display("busy or response raised with no request");
                tb_errors++;
            end
        end
    endtask

    // Monitor counts settle one edge after the last response
    task automatic finish_test(input string name);
        int total;
        @(posedge i_clk);
        total = tb_errors + mon_errors;
        if (total == errors_before) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, total - errors_before);
        errors_before = total;
        tests_run++;
    endtask

    initial begin
        logic [15:0] offset;
        int          total;
        void'($urandom(32'head6_121b));
        i_reset     <= 1'b1;
        i_req       <= 1'b0;
        i_req_write <= 1'b0;
        i_req_addr  <= '0;
        i_req_wdata <= 4'd0;
        exp_push    <= 1'b0;
        exp_hit     <= 1'b0;
        exp_data    <= 4'd0;
        repeat (8) @(posedge i_clk);
        i_reset <= 1'b0;

        check_ring();
        finish_test("reset state");

        repeat (12) run_transaction(1'b0, {ROM_BANK, 16'($urandom)}, 4'd0, 1'b0);
        // ROM writes claim the bank and read back zero
        repeat (3) run_transaction(1'b1, {ROM_BANK, 16'($urandom)}, 4'($urandom), 1'b0);
        finish_test("rom reads");

        repeat (40) begin
            offset = 16'($urandom);
            if (written.size() == 0 || $urandom_range(0, 1) == 0) begin
                // Reuse an index now and then, with new upper bits
                if (written.size() != 0 && $urandom_range(0, 1) == 0) begin
                    offset[RAM_ADDR_BITS-1:0] = written[$urandom_range(0, written.size() - 1)];
                end
                written.push_back(offset[RAM_ADDR_BITS-1:0]);
                run_transaction(1'b1, {RAM_BANK, offset}, 4'($urandom), 1'b0);
            end else begin
                offset[RAM_ADDR_BITS-1:0] = written[$urandom_range(0, written.size() - 1)];
                run_transaction(1'b0, {RAM_BANK, offset}, 4'd0, 1'b0);
            end
        end
        finish_test("ram round trip");

        repeat (10) begin
            run_transaction(1'($urandom), {4'($urandom_range(2, 15)), 16'($urandom)},
                            4'($urandom), 1'b0);
        end
        finish_test("unmapped bank");

        // Reads of written entries also catch a dropped write that slipped in
        repeat (8) begin
            offset = 16'($urandom);
            offset[RAM_ADDR_BITS-1:0] = written[$urandom_range(0, written.size() - 1)];
            run_transaction(1'b0, {RAM_BANK, offset}, 4'd0, 1'b1);
        end
        finish_test("dropped requests");

        if (mon_responses != accepted || mon_pending != 0) begin
            $display("%0d responses seen for %0d accepted requests", mon_responses, accepted);
            tb_errors++;
        end
        total = tb_errors + mon_errors;
        $display("%0d tests, %0d requests accepted, %0d responses, %0d errors",
                 tests_run, accepted, mon_responses, total);
        if (total == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/saturn_bus_monitor.sv */
// Saturn bus monitor pairing each response with the expected answer queued at acceptance
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_monitor (
    input  wire       i_clk,
    input  wire       i_reset,
    input  wire       i_resp_valid,
    input  wire       i_resp_hit,
    input  wire [3:0] i_resp_data,
    input  wire       i_exp_push,
    input  wire       i_exp_hit,
    input  wire [3:0] i_exp_data,
    output int        o_error_count,
    output int        o_resp_count,
    output int        o_pending
);

    // Expected {hit, data}, oldest first
    logic [4:0] pending [$];

    always @(posedge i_clk) begin
        logic [4:0] expected;
        int         errors;
        errors   = 0;
        expected = 5'd0;
        if (i_reset) begin
            pending.delete();
            o_error_count <= 0;
            o_resp_count  <= 0;
        end else begin
            if (i_exp_push) begin
                pending.push_back({i_exp_hit, i_exp_data});
            end
            if (i_resp_valid) begin
                o_resp_count <= o_resp_count + 1;
                // Extra pulse means a dropped request got through
                if (pending.size() == 0) begin
                    $display("response arrived with no accepted request waiting");
                    errors++;
                end else begin
                    expected = pending.pop_front();
                    if (i_resp_hit !== expected[4]) begin
                        $display("mismatch o_resp_hit: expected 0x%h got 0x%h",
                                 expected[4], i_resp_hit);
                        errors++;
                    end
                    if (i_resp_data !== expected[3:0]) begin
                        $display("mismatch o_resp_data: expected 0x%h got 0x%h",
                                 expected[3:0], i_resp_data);
                        errors++;
                    end
                end
            end
            o_error_count <= o_error_count + errors;
        end
        o_pending <= pending.size();
    end

endmodule

`default_nettype wire

/* verification/saturn_bus_chk.sv */
// Saturn bus checker with concurrent assertions on the phase ring, strobe and response pulse
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_chk (
    input wire        i_clk,
    input wire        i_reset,
    input wire [1:0]  i_phase,
    input wire        i_strobe,
    input wire        i_busy,
    input wire        i_resp_valid,
    input wire [31:0] i_cycle_ctr
);

    // Ring steps by one every clock and wraps 3 to 0
    phase_steps: assert property (@(posedge i_clk) disable iff (i_reset)
        !$past(i_reset) |-> i_phase == $past(i_phase) + 2'd1)
        else $error("phase ring did not advance by one step");

    // Counter moves only on the wrap into phase 0
    cycle_counts: assert property (@(posedge i_clk) disable iff (i_reset)
        !$past(i_reset)
        |-> i_cycle_ctr == $past(i_cycle_ctr)
            + ((i_phase == saturn_bus_pkg::PHASE_ADDR) ? 32'd1 : 32'd0))
        else $error("cycle counter out of step with the 3 to 0 wrap");

    // Strobe belongs to phase 0
    strobe_in_addr: assert property (@(posedge i_clk) disable iff (i_reset)
        i_strobe |-> i_phase == saturn_bus_pkg::PHASE_ADDR)
        else $error("strobe outside phase 0");

    // Response sits in phase 3 with the controller already idle
    resp_in_done: assert property (@(posedge i_clk) disable iff (i_reset)
        i_resp_valid |-> i_phase == saturn_bus_pkg::PHASE_DONE && !i_busy)
        else $error("response outside phase 3 or while busy");

    // Single cycle pulse
    resp_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_resp_valid |=> !i_resp_valid)
        else $error("response valid held for more than one cycle");

endmodule

bind saturn_bus_controller saturn_bus_chk u_chk (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_phase      (phase),
    .i_strobe     (strobe),
    .i_busy       (o_busy),
    .i_resp_valid (o_resp_valid),
    .i_cycle_ctr  (o_cycle_ctr)
);

`default_nettype wire

/* verilog/saturn_bus.sv */
// Saturn bus top level wiring the controller, the ROM, the RAM and the answer combiner
`timescale 1ns/1ps
`default_nettype none

module saturn_bus #(
    parameter logic [3:0] ROM_BANK      = 4'd0,
    parameter logic [3:0] RAM_BANK      = 4'd1,
    parameter int         RAM_ADDR_BITS = 6
) (
    input  wire                              i_clk,
    input  wire                              i_reset,
    input  wire                              i_req,
    input  wire                              i_req_write,
    input  wire [saturn_map_pkg::ADDR_W-1:0] i_req_addr,
    input  wire [3:0]                        i_req_wdata,
    output logic                             o_busy,
    output logic                             o_resp_valid,
    output logic                             o_resp_hit,
    output logic [3:0]                       o_resp_data,
    output logic [1:0]                       o_phase,
    output logic [31:0]                      o_cycle_ctr
);

    saturn_nibble_bus_if bus ();

    // Device answers
    logic       rom_drive;
    logic [3:0] rom_nibble;
    logic       ram_drive;
    logic [3:0] ram_nibble;

    // Merged answer back to the controller
    logic       bus_hit;
    logic [3:0] bus_nibble;

    saturn_bus_controller u_controller (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req        (i_req),
        .i_req_write  (i_req_write),
        .i_req_addr   (i_req_addr),
        .i_req_wdata  (i_req_wdata),
        .i_hit        (bus_hit),
        .i_nibble     (bus_nibble),
        .o_busy       (o_busy),
        .o_resp_valid (o_resp_valid),
        .o_resp_hit   (o_resp_hit),
        .o_resp_data  (o_resp_data),
        .o_phase      (o_phase),
        .o_cycle_ctr  (o_cycle_ctr),
        .bus          (bus.controller)
    );

    // Firmware lives in its own bank
    saturn_rom #(
        .ROM_BANK (ROM_BANK)
    ) u_rom (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .bus      (bus.device),
        .o_drive  (rom_drive),
        .o_nibble (rom_nibble)
    );

    saturn_ram #(
        .RAM_BANK      (RAM_BANK),
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) u_ram (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .bus      (bus.device),
        .o_drive  (ram_drive),
        .o_nibble (ram_nibble)
    );

    saturn_bus_combiner u_combiner (
        .i_rom_drive  (rom_drive),
        .i_rom_nibble (rom_nibble),
        .i_ram_drive  (ram_drive),
        .i_ram_nibble (ram_nibble),
        .o_hit        (bus_hit),
        .o_nibble     (bus_nibble)
    );

endmodule

`default_nettype wire

/* verilog/saturn_bus_combiner.sv */
// Saturn bus combiner merging device answers by priority, where the last active device wins
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_combiner (
    input  wire        i_rom_drive,
    input  wire  [3:0] i_rom_nibble,
    input  wire        i_ram_drive,
    input  wire  [3:0] i_ram_nibble,
    output logic       o_hit,
    output logic [3:0] o_nibble
);

    // Devices walked in bus order, RAM last
    always_comb begin
        // Idle bus reads as zero
        o_nibble = 4'd0;
        if (i_rom_drive) begin
            o_nibble = i_rom_nibble;
        end
        if (i_ram_drive) begin
            o_nibble = i_ram_nibble;
        end
    end

    // Any claim counts as a hit
    assign o_hit = i_rom_drive | i_ram_drive;

endmodule

`default_nettype wire

/* verilog/saturn_ram.sv */
// Saturn nibble RAM answering reads and writes in its bank
`timescale 1ns/1ps
`default_nettype none

module saturn_ram #(
    parameter logic [3:0] RAM_BANK      = 4'd1,
    parameter int         RAM_ADDR_BITS = 6
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    saturn_nibble_bus_if.device bus,
    output logic                o_drive,
    output logic [3:0]          o_nibble
);

    localparam int RAM_DEPTH = 1 << RAM_ADDR_BITS;

    logic [3:0] mem [0:RAM_DEPTH-1];

    // Transaction captured in phase 0
    logic                     sel;
    logic                     is_write;
    logic [RAM_ADDR_BITS-1:0] index;
    logic [3:0]               wdata;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sel     <= 1'b0;
            o_drive <= 1'b0;
        end else begin
            case (bus.phase)
                saturn_bus_pkg::PHASE_ADDR: begin
                    if (bus.strobe) begin
                        sel <= (bus.addr.banked.bank == RAM_BANK);
                    end
                end
                saturn_bus_pkg::PHASE_ACCESS: o_drive <= sel;
                saturn_bus_pkg::PHASE_DATA: begin
                    o_drive <= 1'b0;
                    sel     <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.phase == saturn_bus_pkg::PHASE_ADDR && bus.strobe) begin
            is_write <= (bus.cmd == saturn_bus_pkg::CMD_WRITE);
            // Upper offset bits alias onto the same entry
            index    <= bus.addr.banked.offset[RAM_ADDR_BITS-1:0];
            wdata    <= bus.wdata;
        end
        if (bus.phase == saturn_bus_pkg::PHASE_ACCESS) begin
            if (sel && is_write) begin
                mem[index] <= wdata;
            end
            // Write answers with zero
            o_nibble <= is_write ? 4'd0 : mem[index];
        end
    end

endmodule

`default_nettype wire

/* verilog/saturn_rom.sv */
// Saturn firmware ROM whose nibbles follow a fixed rule, answering reads in its bank
`timescale 1ns/1ps
`default_nettype none

module saturn_rom #(
    parameter logic [3:0] ROM_BANK = 4'd0
) (
    input  wire                 i_clk,
    input  wire                 i_reset,
    saturn_nibble_bus_if.device bus,
    output logic                o_drive,
    output logic [3:0]          o_nibble
);

    // Bank claimed by the strobed transaction
    logic sel;
    logic is_read;
    // Offset nibbles 15:12, 11:8 and 3:0
    logic [11:0] key;

    // Sum of three offset nibbles, wraps at 16
    function automatic logic [3:0] rom_rule(input logic [11:0] k);
        return k[11:8] + k[7:4] + k[3:0];
    endfunction

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            sel     <= 1'b0;
            o_drive <= 1'b0;
        end else begin
            case (bus.phase)
                saturn_bus_pkg::PHASE_ADDR: begin
                    if (bus.strobe) begin
                        sel <= (bus.addr.banked.bank == ROM_BANK);
                    end
                end
                saturn_bus_pkg::PHASE_ACCESS: o_drive <= sel;
                saturn_bus_pkg::PHASE_DATA: begin
                    o_drive <= 1'b0;
                    sel     <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (bus.phase == saturn_bus_pkg::PHASE_ADDR && bus.strobe) begin
            is_read <= (bus.cmd == saturn_bus_pkg::CMD_READ);
            key     <= {bus.addr.banked.offset[15:8], bus.addr.banked.offset[3:0]};
        end
        // Writes claim the bank but read back zero
        if (bus.phase == saturn_bus_pkg::PHASE_ACCESS) begin
            o_nibble <= is_read ? rom_rule(key) : 4'd0;
        end
    end

endmodule

`default_nettype wire

/* verilog/saturn_bus_controller.sv */
// Saturn bus controller running the phase ring, the cycle counter and one transaction at a time
`timescale 1ns/1ps
`default_nettype none

module saturn_bus_controller (
    input  wire                              i_clk,
    input  wire                              i_reset,
    input  wire                              i_req,
    input  wire                              i_req_write,
    input  wire [saturn_map_pkg::ADDR_W-1:0] i_req_addr,
    input  wire [3:0]                        i_req_wdata,
    input  wire                              i_hit,
    input  wire [3:0]                        i_nibble,
    output logic                             o_busy,
    output logic                             o_resp_valid,
    output logic                             o_resp_hit,
    output logic [3:0]                       o_resp_data,
    output logic [1:0]                       o_phase,
    output logic [31:0]                      o_cycle_ctr,
    saturn_nibble_bus_if.controller          bus
);

    // One-hot phase ring, bit n set in phase n
    logic [3:0] phases;
    logic [1:0] phase;

    // Request held from acceptance until the response
    logic                         req_write;
    saturn_map_pkg::saturn_addr_u req_addr;
    logic [3:0]                   req_wdata;

    // Strobed and waiting for the device answer
    logic active;
    logic strobe;

    // Encode the ring for the bus and the port
    always_comb begin
        phase = saturn_bus_pkg::PHASE_ADDR;
        if (phases[1]) phase = saturn_bus_pkg::PHASE_ACCESS;
        if (phases[2]) phase = saturn_bus_pkg::PHASE_DATA;
        if (phases[3]) phase = saturn_bus_pkg::PHASE_DONE;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            phases       <= 4'b0001;
            o_cycle_ctr  <= 32'd0;
            o_busy       <= 1'b0;
            active       <= 1'b0;
            strobe       <= 1'b0;
            o_resp_valid <= 1'b0;
            o_resp_hit   <= 1'b0;
        end else begin
            phases <= {phases[2:0], phases[3]};
            // Phase 3 wraps to 0, so a new bus cycle starts
            o_cycle_ctr <= o_cycle_ctr + {31'd0, phases[3]};

            // Response lives for one cycle only
            o_resp_valid <= 1'b0;

            // Accept only when idle, drop the request otherwise
            if (i_req && !o_busy) begin
                o_busy <= 1'b1;
            end

            // Pending request goes out in the coming phase 0
            if (phases[3] && o_busy && !active) begin
                strobe <= 1'b1;
                active <= 1'b1;
            end

            if (phases[0]) begin
                strobe <= 1'b0;
            end

            // Combined answer is valid during phase 2
            if (phases[2] && active) begin
                o_resp_valid <= 1'b1;
                o_resp_hit   <= i_hit;
                active       <= 1'b0;
                o_busy       <= 1'b0;
            end
        end
    end

    // Request payload and response nibble
    always_ff @(posedge i_clk) begin
        if (i_req && !o_busy) begin
            req_write     <= i_req_write;
            req_addr.flat <= i_req_addr;
            req_wdata     <= i_req_wdata;
        end
        if (phases[2] && active) begin
            o_resp_data <= i_nibble;
        end
    end

    assign o_phase = phase;

    assign bus.phase  = phase;
    assign bus.strobe = strobe;
    assign bus.cmd    = !strobe   ? saturn_bus_pkg::CMD_NONE :
                        req_write ? saturn_bus_pkg::CMD_WRITE : saturn_bus_pkg::CMD_READ;
    assign bus.addr   = req_addr;
    assign bus.wdata  = req_wdata;

endmodule

`default_nettype wire

/* verilog/saturn_nibble_bus_if.sv */
// Saturn nibble bus interface between the bus controller and the bus devices
`timescale 1ns/1ps
`default_nettype none

interface saturn_nibble_bus_if;

    // Current phase of the bus cycle
    logic [1:0]                   phase;
    // High only in the phase 0 of an active transaction
    logic                         strobe;
    // Command and address, meaningful while strobe is high
    saturn_bus_pkg::bus_cmd_e     cmd;
    saturn_map_pkg::saturn_addr_u addr;
    // Nibble to store on a write
    logic [3:0]                   wdata;

    // Bus master side
    modport controller (
        output phase,
        output strobe,
        output cmd,
        output addr,
        output wdata
    );

    // Listening side for every device
    modport device (
        input phase,
        input strobe,
        input cmd,
        input addr,
        input wdata
    );

endinterface

`default_nettype wire

/* verilog/saturn_map_pkg.sv */
// Saturn address map package with the nibble address width and its bank and offset views
`default_nettype none

package saturn_map_pkg;

    // 20-bit nibble address
    localparam int ADDR_W   = 20;
    // Top nibble picks the bank
    localparam int BANK_W   = 4;
    localparam int OFFSET_W = ADDR_W - BANK_W;

    // Bank view of an address
    typedef struct packed {
        logic [BANK_W-1:0]   bank;
        logic [OFFSET_W-1:0] offset;
    } bank_addr_s;

    // Same 20 bits seen two ways
    // flat is what the requester hands over
    // banked is what a device decodes
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        bank_addr_s        banked;
    } saturn_addr_u;

endpackage

`default_nettype wire

/* verilog/saturn_bus_pkg.sv */
// Saturn bus protocol package with the bus command codes and the phase numbering of a bus cycle
`default_nettype none

package saturn_bus_pkg;

    // Command carried with the strobe
    typedef enum logic [1:0] {
        CMD_NONE  = 2'd0,
        CMD_READ  = 2'd1,
        CMD_WRITE = 2'd2
    } bus_cmd_e;

    // Four phases of one bus cycle
    // Address goes out in phase 0
    localparam logic [1:0] PHASE_ADDR   = 2'd0;
    // Devices access storage
    localparam logic [1:0] PHASE_ACCESS = 2'd1;
    // Devices drive the answer
    localparam logic [1:0] PHASE_DATA   = 2'd2;
    // Response presented to the requester
    localparam logic [1:0] PHASE_DONE   = 2'd3;

endpackage

`default_nettype wire
